/* run_sim.sh */
#!/bin/sh
# build and run the tx_fsrc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_tx_fsrc -f verilog.f
./obj_dir/Vtb_tx_fsrc | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* sim/tb_tx_fsrc.sv */
// ==========================================================================
// testbench for tx_fsrc
// stimulus file reader, stream driver, queue-based reference model,
// output checks and watchdog
// ==========================================================================

`timescale 1ns/1ps

module tb_tx_fsrc
  import fsrc_pkg::*;
();

  logic                                          clk = 1'b0;
  logic                                          reset;
  logic                                          enable;
  logic                                          start;
  logic                                          stop;
  logic [NUM_CHANNELS-1:0]                       conv_mask;
  logic                                          accum_set;
  logic [SLOTS_PER_CHANNEL-1:0][ACCUM_WIDTH-1:0] accum_set_val;
  logic [ACCUM_WIDTH-1:0]                        accum_add_val;
  logic                                          in_valid;
  logic                                          in_ready;
  logic [DATA_WIDTH-1:0]                         in_data;
  logic                                          out_valid;
  logic                                          out_ready;
  logic [DATA_WIDTH-1:0]                         out_data;

  logic [31:0]                                   rec_kw [$];
  logic [DATA_WIDTH-1:0]                         rec_val [$];
  logic [DATA_WIDTH-1:0]                         exp_q [$];
  logic [NUM_CHANNELS-1:0][SAMPLE_WIDTH-1:0]     samp_q [$];  // one entry per slot
  logic [ACCUM_WIDTH-1:0]                        m_acc [SLOTS_PER_CHANNEL];
  logic [SLOTS_PER_CHANNEL-1:0]                  m_holes;
  logic                                          m_conv;
  logic [31:0]                                   lfsr = 32'h43dde742;
  logic                                          bp_mode = 1'b0;
  logic                                          stalled;
  logic [DATA_WIDTH-1:0]                         held_data;
  int                                            word_count = 0;
  bit                                            loaded = 1'b0;

  tx_fsrc dut_i (.*);

  always #20 clk = ~clk;

  task automatic check_value(input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // x^32+x^22+x^2+x+1
  endfunction

  // form every word the buffered samples allow
  task automatic model_form();
    bus_word_t               w;
    logic [NUM_CHANNELS-1:0] active;
    logic [ACCUM_WIDTH:0]    sum;
    int                      nvalid;
    int                      guard;
    active = enable ? conv_mask : '1;
    guard  = 0;
    nvalid = SLOTS_PER_CHANNEL - (m_conv ? $countones(m_holes) : 0);
    while (samp_q.size() >= nvalid && guard < 8) begin
      for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
        if (m_conv && m_holes[s])
          w.grid[s] = {NUM_CHANNELS{HOLE_SAMPLE}};
        else
          w.grid[s] = samp_q.pop_front();  // low slot takes the older sample
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (!active[c]) begin
          w.grid[0][c] = HOLE_SAMPLE;
          w.grid[1][c] = HOLE_SAMPLE;
        end
      end
      exp_q.push_back(w.flat);
      if (m_conv) begin
        for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
          sum        = {1'b0, m_acc[s]} + {1'b0, accum_add_val};
          m_acc[s]   = sum[ACCUM_WIDTH-1:0];
          m_holes[s] = sum[ACCUM_WIDTH];  // carry marks next word's hole
        end
      end
      nvalid = SLOTS_PER_CHANNEL - (m_conv ? $countones(m_holes) : 0);
      guard++;
    end
  endtask

  task automatic send_word(input logic [DATA_WIDTH-1:0] word);
    bus_word_t w;
    w.flat   = word;
    in_valid = 1'b1;
    in_data  = word;
    @(posedge clk);
    while (!in_ready)
      @(posedge clk);
    for (int s = 0; s < SLOTS_PER_CHANNEL; s++)
      samp_q.push_back(w.grid[s]);
    model_form();
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic load_stimulus();
    int                    fd;
    int                    n;
    logic [31:0]           kw;
    logic [DATA_WIDTH-1:0] val;
    logic [8*160-1:0]      line;
    logic [31:0]           en, mask, add, s0, s1;
    fd = $fopen("sim/tx_fsrc_stim.txt", "r");
    if (fd == 0)
      report_failure("cannot open stimulus file sim/tx_fsrc_stim.txt");
    while (!$feof(fd)) begin
      kw  = '0;
      val = '0;
      n   = $fscanf(fd, "%s", kw);
      if (n != 1)
        break;
      if (kw == 32'("#")) begin
        n = $fgets(line, fd);
        continue;
      end
      if (kw == 32'("cfg")) begin
        n   = $fscanf(fd, "%h %h %h %h %h", en, mask, add, s0, s1);
        val = {75'd0, en[0], mask[3:0], add[15:0], s1[15:0], s0[15:0]};
      end else if (kw == 32'("word") || kw == 32'("bp")) begin
        n = $fscanf(fd, "%h", val);
        if (kw == 32'("word"))
          word_count++;
      end else if (kw != 32'("go") && kw != 32'("halt")) begin
        report_failure("unknown keyword in stimulus file");
      end
      rec_kw.push_back(kw);
      rec_val.push_back(val);
    end
    $fclose(fd);
  endtask

  initial begin
    reset         = 1'b1;
    enable        = 1'b0;
    start         = 1'b0;
    stop          = 1'b0;
    conv_mask     = '1;
    accum_set     = 1'b0;
    accum_set_val = '0;
    accum_add_val = '0;
    in_valid      = 1'b0;
    in_data       = '0;
    out_ready     = 1'b1;
    m_conv        = 1'b0;
    m_holes       = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value(DATA_WIDTH'(out_valid), '0, "out_valid after reset");
    check_value(DATA_WIDTH'(in_ready), '0, "in_ready right after reset");
    for (int i = 0; i < rec_kw.size(); i++) begin
      if (rec_kw[i] == 32'("word")) begin
        send_word(rec_val[i]);
      end else if (rec_kw[i] == 32'("bp")) begin
        bp_mode = rec_val[i][0];
      end else begin
        wait_drained();  // mode changes only on an idle stream
        if (rec_kw[i] == 32'("cfg")) begin
          {enable, conv_mask, accum_add_val, accum_set_val} = rec_val[i][52:0];
          accum_set = 1'b1;
          for (int s = 0; s < SLOTS_PER_CHANNEL; s++)
            m_acc[s] = accum_set_val[s];
          m_holes = '0;
          if (!enable)
            m_conv = 1'b0;
        end else if (rec_kw[i] == 32'("go")) begin
          start = 1'b1;
          if (enable)
            m_conv = 1'b1;
        end else begin
          stop   = 1'b1;
          m_conv = 1'b0;
        end
        @(posedge clk);
        #2;
        accum_set = 1'b0;
        start     = 1'b0;
        stop      = 1'b0;
        model_form();
      end
    end
    wait_drained();
    repeat (10) @(posedge clk);  // room for a stray extra word
    $display("Test completed successfully");
    $finish;
  end

  always @(posedge clk) begin
    #2;
    if (bp_mode) begin
      lfsr      = lfsr_step(lfsr);  // one step per bit taken
      out_ready = lfsr[0];
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check_value(DATA_WIDTH'(out_valid), DATA_WIDTH'(1), "out_valid dropped while stalled");
        check_value(out_data, held_data, "out_data changed while stalled");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0)
          report_failure("output word arrived when none was expected");
        else
          check_value(out_data, exp_q.pop_front(), "output word");
      end
      stalled   = out_valid && !out_ready;
      held_data = out_data;
    end
  end

  initial begin
    wait (loaded);
    repeat (60 * word_count + 200) @(posedge clk);
    report_failure("timeout, expected output words did not arrive");
  end

endmodule

/* sim/tx_fsrc_stim.txt */
# cfg enable conv_mask add_val set0 set1 | go | halt | bp out_ready_mode (0 steady, 1 random)
# word 128-bit hex, slot 1 channel 3 in the top 16 bits, slot 0 channel 0 in the low 16
bp 0
cfg 0 f 2800 0000 8000
word 01310121011101010130012001100100
word 02310221021102010230022002100200
word 03310321031103010330032003100300
bp 1
word 04310421041104010430042004100400
word 05310521051105010530052005100500
cfg 1 5 2800 0000 8000
word 06310621061106010630062006100600
word 07310721071107010730072007100700
go
word 08310821081108010830082008100800
word 09310921091109010930092009100900
word 0a310a210a110a010a300a200a100a00
word 0b310b210b110b010b300b200b100b00
word 0c310c210c110c010c300c200c100c00
word 0d310d210d110d010d300d200d100d00
halt
word 0e310e210e110e010e300e200e100e00
word 0f310f210f110f010f300f200f100f00
cfg 0 f 0000 0000 0000
word 10311021101110011030102010101000
word 11311121111111011130112011101100
cfg 1 b 1800 4000 c000
go
word 12311221121112011230122012101200
word 13311321131113011330132013101300
word 14311421141114011430142014101400
word 15311521151115011530152015101500
halt
cfg 0 f 0000 0000 0000
word 16311621161116011630162016101600

/* verilog.f */
verilog/fsrc_pkg.sv
verilog/fsrc_lane_fifo.sv
verilog/fsrc_phase_accum.sv
verilog/fsrc_hole_inserter.sv
verilog/tx_fsrc.sv
sim/tb_tx_fsrc.sv

/* verilog/fsrc_hole_inserter.sv */
// ==========================================================================
// hole inserter: per-channel sample buffer with one shared fill count
// output words mix buffered samples and hole samples by slot
// ==========================================================================

`timescale 1ns/1ps

module fsrc_hole_inserter
  import fsrc_pkg::*;
(
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              converting,
  input  logic [NUM_CHANNELS-1:0]           chan_active,

  input  logic [SLOTS_PER_CHANNEL-1:0]      hole_slots,
  output logic                              advance,

  input  logic                              in_valid,
  output logic                              in_ready,
  input  lane_word_t [NUM_CHANNELS-1:0]     in_data,

  output logic                              out_valid,
  input  logic                              out_ready,
  output lane_word_t [NUM_CHANNELS-1:0]     out_data
);

  logic [NUM_CHANNELS-1:0][BUF_DEPTH-1:0][SAMPLE_WIDTH-1:0] sample_buf;
  logic [NUM_CHANNELS-1:0][BUF_DEPTH-1:0][SAMPLE_WIDTH-1:0] buf_next;
  lane_word_t [NUM_CHANNELS-1:0]                            word_next;

  logic [FILL_WIDTH-1:0] fill;
  logic [FILL_WIDTH-1:0] fill_next;
  logic [FILL_WIDTH-1:0] nvalid;    // slots that take a real sample
  logic [FILL_WIDTH-1:0] consumed;
  logic [FILL_WIDTH-1:0] base;      // fill after consumption
  logic [FILL_WIDTH-1:0] rd_idx;
  logic                  form;
  logic                  push;

  assign in_ready = (fill <= FILL_WIDTH'(BUF_DEPTH - SLOTS_PER_CHANNEL));
  assign push     = in_valid && in_ready;
  assign form     = (fill >= nvalid) && (!out_valid || out_ready);
  assign advance  = form && converting;

  always_comb begin
    nvalid = FILL_WIDTH'(SLOTS_PER_CHANNEL);
    for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
      if (converting && hole_slots[s])
        nvalid = nvalid - 1'b1;
    end
  end

  // next output word, holes first then samples in slot order
  always_comb begin
    word_next = '0;
    rd_idx    = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      rd_idx = '0;
      for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
        if (converting && hole_slots[s]) begin
          word_next[c][s] = HOLE_SAMPLE;
        end else begin
          word_next[c][s] = sample_buf[c][rd_idx];
          rd_idx          = rd_idx + 1'b1;
        end
      end
      if (!chan_active[c])
        word_next[c] = {SLOTS_PER_CHANNEL{HOLE_SAMPLE}};  // masked channel
    end
  end

  // shift out consumed samples, then append the incoming word
  always_comb begin
    consumed = form ? nvalid : '0;
    base     = fill - consumed;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int k = 0; k < BUF_DEPTH; k++) begin
        if (k + consumed < BUF_DEPTH)
          buf_next[c][k] = sample_buf[c][k + consumed];
        else
          buf_next[c][k] = sample_buf[c][k];
        for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
          if (push && (k == base + s))
            buf_next[c][k] = in_data[c][s];
        end
      end
    end
    fill_next = base + (push ? FILL_WIDTH'(SLOTS_PER_CHANNEL) : '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill      <= '0;
      out_valid <= 1'b0;
    end else begin
      fill <= fill_next;
      if (form)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    sample_buf <= buf_next;
    if (form)
      out_data <= word_next;
  end

endmodule

/* verilog/fsrc_lane_fifo.sv */
// ==========================================================================
// two-entry synchronous FIFO with registered in_ready and out_valid
// ==========================================================================

`timescale 1ns/1ps

module fsrc_lane_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,

  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,

  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic [WIDTH-1:0] mem [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic [1:0]       count_next;
  logic             push;
  logic             pop;

  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;
  assign out_data = mem[rd_ptr];

  always_comb begin
    count_next = count + {1'b0, push} - {1'b0, pop};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count     <= 2'd0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      in_ready  <= 1'b0;  // held low for the reset cycle
      out_valid <= 1'b0;
    end else begin
      count     <= count_next;
      in_ready  <= (count_next != 2'd2);  // occupancy only
      out_valid <= (count_next != 2'd0);
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

/* verilog/fsrc_phase_accum.sv */
// ==========================================================================
// per-slot phase accumulators for the hole pattern
// the carry out of each accumulator marks its slot as a hole
// ==========================================================================

`timescale 1ns/1ps

module fsrc_phase_accum
  import fsrc_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          reset,

  input  logic                                          set,
  input  logic [SLOTS_PER_CHANNEL-1:0][ACCUM_WIDTH-1:0] set_val,

  input  logic [ACCUM_WIDTH-1:0]                        add_val,
  input  logic                                          advance,

  output logic [SLOTS_PER_CHANNEL-1:0]                  hole_slots
);

  logic [SLOTS_PER_CHANNEL-1:0][ACCUM_WIDTH-1:0] accum;
  logic [SLOTS_PER_CHANNEL-1:0][ACCUM_WIDTH-1:0] sum;
  logic [SLOTS_PER_CHANNEL-1:0]                  carry;

  // one adder per slot, carry is the overflow bit
  always_comb begin
    for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
      {carry[s], sum[s]} = {1'b0, accum[s]} + {1'b0, add_val};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      accum      <= '0;
      hole_slots <= '0;
    end else if (set) begin
      accum      <= set_val;  // per-slot start phase
      hole_slots <= '0;       // next word has no holes
    end else if (advance) begin
      accum      <= sum;      // wraps modulo 2^ACCUM_WIDTH
      hole_slots <= carry;
    end
  end

endmodule

/* verilog/fsrc_pkg.sv */
// ==========================================================================
// shared definitions for the fractional sample-rate converter (transmit)
// geometry constants, hole sample value, bus word and lane word types
// ==========================================================================

package fsrc_pkg;

  // stream geometry
  localparam int NUM_CHANNELS      = 4;
  localparam int SAMPLE_WIDTH      = 16;
  localparam int SLOTS_PER_CHANNEL = 2;
  localparam int DATA_WIDTH        = 128;
  localparam int ACCUM_WIDTH       = 16;

  // one channel's share of a bus word
  localparam int CHANNEL_WIDTH = SAMPLE_WIDTH * SLOTS_PER_CHANNEL;

  // inserter sample buffer, two words deep per channel
  localparam int BUF_DEPTH  = 2 * SLOTS_PER_CHANNEL;
  localparam int FILL_WIDTH = $clog2(BUF_DEPTH + 1);

  // invalid sample marker
  localparam logic [SAMPLE_WIDTH-1:0] HOLE_SAMPLE = 16'h8000;

  // samples of one channel, slot 0 in the low bits
  typedef logic [SLOTS_PER_CHANNEL-1:0][SAMPLE_WIDTH-1:0] lane_word_t;

  // external bus word, two views of the same bits
  typedef union packed {
    logic [DATA_WIDTH-1:0] flat;                          // raw bus bits
    logic [SLOTS_PER_CHANNEL-1:0][NUM_CHANNELS-1:0]
          [SAMPLE_WIDTH-1:0] grid;                        // [slot][channel]
  } bus_word_t;

endpackage

/* verilog/tx_fsrc.sv */
// ==========================================================================
// transmit-side fractional sample-rate converter, top level
// mode control, deinterleave, input FIFOs, hole insertion, output FIFO
// and re-interleave for the downstream unpacker
// ==========================================================================

`timescale 1ns/1ps

module tx_fsrc
  import fsrc_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          reset,

  input  logic                                          enable,
  input  logic                                          start,
  input  logic                                          stop,
  input  logic [NUM_CHANNELS-1:0]                       conv_mask,

  input  logic                                          accum_set,
  input  logic [SLOTS_PER_CHANNEL-1:0][ACCUM_WIDTH-1:0] accum_set_val,
  input  logic [ACCUM_WIDTH-1:0]                        accum_add_val,

  input  logic                                          in_valid,
  output logic                                          in_ready,
  input  logic [DATA_WIDTH-1:0]                         in_data,

  output logic                                          out_valid,
  input  logic                                          out_ready,
  output logic [DATA_WIDTH-1:0]                         out_data
);

  bus_word_t                     in_word;
  bus_word_t                     out_word;
  lane_word_t [NUM_CHANNELS-1:0] in_lanes;
  lane_word_t [NUM_CHANNELS-1:0] fifo_lanes;
  lane_word_t [NUM_CHANNELS-1:0] ins_lanes;
  lane_word_t [NUM_CHANNELS-1:0] out_lanes;

  logic [NUM_CHANNELS-1:0]      in_ready_s;
  logic [NUM_CHANNELS-1:0]      fifo_valid;
  logic [NUM_CHANNELS-1:0]      chan_active;
  logic [SLOTS_PER_CHANNEL-1:0] hole_slots;
  logic                         converting;
  logic                         in_push;
  logic                         ins_in_valid;
  logic                         ins_in_ready;
  logic                         ins_pop;
  logic                         ins_out_valid;
  logic                         ins_out_ready;
  logic                         advance;

  always_ff @(posedge clk) begin
    if (reset)
      converting <= 1'b0;
    else if (!enable || stop)
      converting <= 1'b0;
    else if (start)
      converting <= 1'b1;
  end

  assign chan_active = enable ? conv_mask : '1;  // pass-through keeps all

  // interleaved bus to per-channel lanes
  assign in_word.flat = in_data;
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
        in_lanes[c][s] = in_word.grid[s][c];
      end
    end
  end

  assign in_ready     = &in_ready_s;
  assign in_push      = in_valid && in_ready;  // all lanes push together
  assign ins_in_valid = &fifo_valid;
  assign ins_pop      = ins_in_valid && ins_in_ready;

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_in_fifo
    fsrc_lane_fifo #(
      .WIDTH (CHANNEL_WIDTH)
    ) in_fifo_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_push),
      .in_ready  (in_ready_s[c]),
      .in_data   (in_lanes[c]),
      .out_valid (fifo_valid[c]),
      .out_ready (ins_pop),
      .out_data  (fifo_lanes[c])
    );
  end

  fsrc_phase_accum accum_i (
    .clk        (clk),
    .reset      (reset),
    .set        (accum_set),
    .set_val    (accum_set_val),
    .add_val    (accum_add_val),
    .advance    (advance),
    .hole_slots (hole_slots)
  );

  fsrc_hole_inserter inserter_i (
    .clk         (clk),
    .reset       (reset),
    .converting  (converting),
    .chan_active (chan_active),
    .hole_slots  (hole_slots),
    .advance     (advance),
    .in_valid    (ins_in_valid),
    .in_ready    (ins_in_ready),
    .in_data     (fifo_lanes),
    .out_valid   (ins_out_valid),
    .out_ready   (ins_out_ready),
    .out_data    (ins_lanes)
  );

  fsrc_lane_fifo #(
    .WIDTH (DATA_WIDTH)
  ) out_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (ins_out_valid),
    .in_ready  (ins_out_ready),
    .in_data   (ins_lanes),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_lanes)
  );

  // lanes back to interleaved order
  always_comb begin
    for (int s = 0; s < SLOTS_PER_CHANNEL; s++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        out_word.grid[s][c] = out_lanes[c][s];
      end
    end
  end
  assign out_data = out_word.flat;

endmodule
